/* hdl/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

  localparam int xlen  = 32;
  localparam int nregs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  localparam word_t reset_pc = '0;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB and SRA

  typedef enum logic [6:0] {
    op_reg   = 7'b0110011,
    op_imm   = 7'b0010011,
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // LUI result is the immediate
  } alu_op_t;

  typedef struct packed {
    logic    valid;
    alu_op_t alu_op;
    logic    src_a_pc;   // A from PC instead of rs1
    logic    src_b_imm;  // B from immediate instead of rs2
    logic    write_rd;   // Never set for rd of x0
  } ctrl_word_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } wb_bus_t;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  rv32i_pkg::alu_op_t i_op,
  input  rv32i_pkg::word_t   i_a,
  input  rv32i_pkg::word_t   i_b,
  output rv32i_pkg::word_t   o_result
);
  import rv32i_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = i_b[4:0];
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      alu_add:    o_result = i_a + i_b;
      alu_sub:    o_result = i_a - i_b;
      alu_sll:    o_result = i_a << shamt;
      alu_slt:    o_result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   o_result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    o_result = i_a ^ i_b;
      alu_srl:    o_result = i_a >> shamt;
      alu_sra:    o_result = word_t'($signed(i_a) >>> shamt);  // Sign fill
      alu_or:     o_result = i_a | i_b;
      alu_and:    o_result = i_a & i_b;
      alu_pass_b: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_advance,
  input  rv32i_pkg::word_t i_imem_data,
  output rv32i_pkg::word_t o_pc,
  output rv32i_pkg::word_t o_id_instr,
  output rv32i_pkg::word_t o_id_pc,
  output logic             o_id_valid
);
  import rv32i_pkg::*;

  word_t pc_q;

  assign o_pc = pc_q;

  // PC and IF/ID register move together on every advancing cycle
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pc_q       <= reset_pc;
      o_id_valid <= 1'b0;
    end else if (i_advance) begin
      pc_q       <= pc_q + word_t'(4);  // No redirection, straight-line fetch
      o_id_valid <= 1'b1;
      o_id_instr <= i_imem_data;
      o_id_pc    <= pc_q;
    end
  end

  // Fetch address stays on a word boundary
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    pc_q[1:0] == 2'b00
  );

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_advance,
  input  rv32i_pkg::word_t       i_instr,
  input  rv32i_pkg::word_t       i_pc,
  input  logic                   i_valid,
  output rv32i_pkg::reg_idx_t    o_rs1_idx,
  output rv32i_pkg::reg_idx_t    o_rs2_idx,
  input  rv32i_pkg::word_t       i_rs1_val,
  input  rv32i_pkg::word_t       i_rs2_val,
  output rv32i_pkg::ctrl_word_t  o_ex_ctrl,
  output rv32i_pkg::word_t       o_ex_pc,
  output rv32i_pkg::word_t       o_ex_imm,
  output rv32i_pkg::word_t       o_ex_rs1_val,
  output rv32i_pkg::word_t       o_ex_rs2_val,
  output rv32i_pkg::reg_idx_t    o_ex_rs1_idx,
  output rv32i_pkg::reg_idx_t    o_ex_rs2_idx,
  output rv32i_pkg::reg_idx_t    o_ex_rd
);
  import rv32i_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm;
  ctrl_word_t ctrl;
  logic       legal;

  // Common mapping for OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_t arith_op(logic [2:0] f3, logic alt);
    alu_op_t op;
    op = alu_add;
    case (f3)
      f3_add_sub: op = alt ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      f3_and:     op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode    = i_instr[6:0];
  assign rd        = i_instr[11:7];
  assign funct3    = i_instr[14:12];
  assign o_rs1_idx = i_instr[19:15];
  assign o_rs2_idx = i_instr[24:20];
  assign funct7    = i_instr[31:25];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {i_instr[31:12], 12'b0};

  always_comb begin
    ctrl  = '0;
    imm   = imm_i;
    legal = 1'b0;
    case (opcode)
      op_reg: begin
        legal = (funct7 == f7_base) ||
                (funct7 == f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
        ctrl.alu_op = arith_op(funct3, funct7[5]);
      end
      op_imm: begin
        if (funct3 == f3_sll) begin
          legal = (funct7 == f7_base);
        end else if (funct3 == f3_srl_sra) begin
          legal = (funct7 == f7_base) || (funct7 == f7_alt);
        end else begin
          legal = 1'b1;
        end
        // No SUBI, the alt bit only matters for shifts
        ctrl.alu_op    = arith_op(funct3, (funct3 == f3_srl_sra) && funct7[5]);
        ctrl.src_b_imm = 1'b1;
      end
      op_lui: begin
        legal          = 1'b1;
        ctrl.alu_op    = alu_pass_b;
        ctrl.src_b_imm = 1'b1;
        imm            = imm_u;
      end
      op_auipc: begin
        legal          = 1'b1;
        ctrl.alu_op    = alu_add;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        imm            = imm_u;
      end
      default: ;  // Anything else goes down as a bubble
    endcase
    ctrl.valid    = i_valid && legal;
    ctrl.write_rd = ctrl.valid && (rd != '0);
  end

  // ID/EX register
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_ex_ctrl <= '0;
    end else if (i_advance) begin
      o_ex_ctrl    <= ctrl;
      o_ex_pc      <= i_pc;
      o_ex_imm     <= imm;
      o_ex_rs1_val <= i_rs1_val;
      o_ex_rs2_val <= i_rs2_val;
      o_ex_rs1_idx <= o_rs1_idx;
      o_ex_rs2_idx <= o_rs2_idx;
      o_ex_rd      <= rd;
    end
  end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  rv32i_pkg::wb_bus_t   i_wb,
  input  rv32i_pkg::reg_idx_t  i_rs1_idx,
  input  rv32i_pkg::reg_idx_t  i_rs2_idx,
  output rv32i_pkg::word_t     o_rs1_val,
  output rv32i_pkg::word_t     o_rs2_val
);
  import rv32i_pkg::*;

  word_t regs [1:nregs-1];  // x0 has no storage

  // Same-cycle write is visible to the reader
  function automatic word_t read_port(reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (i_wb.valid && i_wb.rd == idx) begin
      val = i_wb.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    o_rs1_val = read_port(i_rs1_idx);
    o_rs2_val = read_port(i_rs2_idx);
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.rd != '0) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // Decode drops write_rd for x0, so such a write never reaches here
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_wb.valid |-> i_wb.rd != '0
  );

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_advance,
  input  rv32i_pkg::ctrl_word_t  i_ctrl,
  input  rv32i_pkg::word_t       i_pc,
  input  rv32i_pkg::word_t       i_imm,
  input  rv32i_pkg::word_t       i_rs1_val,
  input  rv32i_pkg::word_t       i_rs2_val,
  input  rv32i_pkg::reg_idx_t    i_rs1_idx,
  input  rv32i_pkg::reg_idx_t    i_rs2_idx,
  input  rv32i_pkg::reg_idx_t    i_rd,
  output rv32i_pkg::wb_bus_t     o_wb
);
  import rv32i_pkg::*;

  word_t rs1_fwd;
  word_t rs2_fwd;
  word_t op_a;
  word_t op_b;
  word_t alu_result;

  // Bypass from the instruction sitting in WB
  function automatic word_t forward(reg_idx_t idx, word_t reg_val, wb_bus_t wb);
    word_t val;
    val = reg_val;
    if (wb.valid && wb.rd == idx) begin
      val = wb.data;  // valid already excludes x0
    end
    return val;
  endfunction

  assign rs1_fwd = forward(i_rs1_idx, i_rs1_val, o_wb);
  assign rs2_fwd = forward(i_rs2_idx, i_rs2_val, o_wb);

  assign op_a = i_ctrl.src_a_pc  ? i_pc  : rs1_fwd;  // AUIPC
  assign op_b = i_ctrl.src_b_imm ? i_imm : rs2_fwd;

  alu i_alu (
    .i_op     (i_ctrl.alu_op),
    .i_a      (op_a),
    .i_b      (op_b),
    .o_result (alu_result)
  );

  // EX/WB register
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wb.valid <= 1'b0;
    end else if (i_advance) begin
      o_wb.valid <= i_ctrl.valid && i_ctrl.write_rd;
      o_wb.rd    <= i_rd;
      o_wb.data  <= alu_result;
    end
  end

endmodule

`default_nettype wire

/* hdl/int_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module int_pipeline (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  rv32i_pkg::word_t     i_imem_data,
  input  logic                 i_imem_resp,
  output rv32i_pkg::word_t     o_imem_addr,
  output logic                 o_wb_valid,
  output rv32i_pkg::reg_idx_t  o_wb_rd,
  output rv32i_pkg::word_t     o_wb_data
);
  import rv32i_pkg::*;

  logic       advance;
  word_t      if_id_instr;
  word_t      if_id_pc;
  logic       if_id_valid;
  reg_idx_t   rs1_idx;
  reg_idx_t   rs2_idx;
  word_t      rs1_val;
  word_t      rs2_val;
  ctrl_word_t ex_ctrl;
  word_t      ex_pc;
  word_t      ex_imm;
  word_t      ex_rs1_val;
  word_t      ex_rs2_val;
  reg_idx_t   ex_rs1_idx;
  reg_idx_t   ex_rs2_idx;
  reg_idx_t   ex_rd;
  wb_bus_t    wb;
  wb_bus_t    wb_commit;

  assign advance = i_imem_resp;  // Whole pipe freezes on a missing fetch

  // Write and retire only when WB is handed over
  always_comb begin
    wb_commit       = wb;
    wb_commit.valid = wb.valid && advance;
  end

  assign o_wb_valid = wb_commit.valid;
  assign o_wb_rd    = wb.rd;
  assign o_wb_data  = wb.data;

  fetch_unit i_fetch_unit (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_advance   (advance),
    .i_imem_data (i_imem_data),
    .o_pc        (o_imem_addr),
    .o_id_instr  (if_id_instr),
    .o_id_pc     (if_id_pc),
    .o_id_valid  (if_id_valid)
  );

  decode_unit i_decode_unit (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_advance    (advance),
    .i_instr      (if_id_instr),
    .i_pc         (if_id_pc),
    .i_valid      (if_id_valid),
    .o_rs1_idx    (rs1_idx),
    .o_rs2_idx    (rs2_idx),
    .i_rs1_val    (rs1_val),
    .i_rs2_val    (rs2_val),
    .o_ex_ctrl    (ex_ctrl),
    .o_ex_pc      (ex_pc),
    .o_ex_imm     (ex_imm),
    .o_ex_rs1_val (ex_rs1_val),
    .o_ex_rs2_val (ex_rs2_val),
    .o_ex_rs1_idx (ex_rs1_idx),
    .o_ex_rs2_idx (ex_rs2_idx),
    .o_ex_rd      (ex_rd)
  );

  reg_file i_reg_file (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_wb      (wb_commit),
    .i_rs1_idx (rs1_idx),
    .i_rs2_idx (rs2_idx),
    .o_rs1_val (rs1_val),
    .o_rs2_val (rs2_val)
  );

  execute_unit i_execute_unit (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_advance (advance),
    .i_ctrl    (ex_ctrl),
    .i_pc      (ex_pc),
    .i_imm     (ex_imm),
    .i_rs1_val (ex_rs1_val),
    .i_rs2_val (ex_rs2_val),
    .i_rs1_idx (ex_rs1_idx),
    .i_rs2_idx (ex_rs2_idx),
    .i_rd      (ex_rd),
    .o_wb      (wb)
  );

endmodule

`default_nettype wire

/* bench/tb_int_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_int_pipeline;

  localparam int reset_cycles = 16;

  logic        clk = 1'b0;
  logic        i_rst_n = 1'b0;
  logic [31:0] i_imem_data = '0;
  logic        i_imem_resp = 1'b0;
  logic [31:0] o_imem_addr;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data;

  logic [31:0] mem [0:255];
  logic [31:0] prog [$];
  logic [36:0] expected [$];  // {rd, data} in retire order
  logic [31:0] model_regs [0:31];
  logic [31:0] lfsr = 32'h88b2_3b3e;
  int          cycles = 0;
  int          cycle_limit = 0;  // Grows with every program that is run

  int_pipeline i_int_pipeline (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_imem_data (i_imem_data),
    .i_imem_resp (i_imem_resp),
    .o_imem_addr (o_imem_addr),
    .o_wb_valid  (o_wb_valid),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("Timeout: no finish within %0d cycles", cycle_limit));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("Mismatch at %0t: %s", $time, msg));
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Unsupported opcode 7'h7f, upper bits hashed from the address
  function automatic logic [31:0] filler_word(input logic [31:0] addr);
    logic [31:0] w;
    w = (addr * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    return {w[31:7], 7'h7f};
  endfunction

  function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                       input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] i_op(input logic [2:0] f3, input int rd,
                                       input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), 7'h13};
  endfunction

  function automatic logic [31:0] u_op(input logic [6:0] opc, input int rd,
                                       input logic [19:0] imm20);
    return {imm20, 5'(rd), opc};
  endfunction

  // In-order ISA model, queues one entry per architectural write
  task automatic model_step(input logic [31:0] instr, input logic [31:0] pc);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ok;
    opc = instr[6:0];
    rd  = instr[11:7];
    f3  = instr[14:12];
    f7  = instr[31:25];
    a   = model_regs[instr[19:15]];
    b   = (opc == 7'h33) ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    ok  = 1'b0;
    res = '0;
    if (opc == 7'h33 || opc == 7'h13) begin
      if (opc == 7'h33) begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end else begin
        ok = (f3 == 3'd1) ? (f7 == 7'h00) :
             (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      end
      case (f3)
        3'd0: res = (opc == 7'h33 && f7[5]) ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = {31'b0, $signed(a) < $signed(b)};
        3'd3: res = {31'b0, a < b};
        3'd4: res = a ^ b;
        3'd5: begin
          if (f7[5]) res = $signed(a) >>> b[4:0];
          else res = a >> b[4:0];
        end
        3'd6: res = a | b;
        3'd7: res = a & b;
      endcase
    end else if (opc == 7'h37) begin
      ok  = 1'b1;
      res = {instr[31:12], 12'b0};
    end else if (opc == 7'h17) begin
      ok  = 1'b1;
      res = pc + {instr[31:12], 12'b0};
    end
    if (ok && rd != 5'd0) begin
      model_regs[rd] = res;
      expected.push_back({rd, res});
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      mem[i] = filler_word(i * 4);
    end
    foreach (prog[i]) mem[i] = prog[i];
    foreach (model_regs[i]) model_regs[i] = '0;
    expected.delete();
    foreach (prog[i]) model_step(prog[i], i * 4);
  endtask

  task automatic apply_reset();
    i_rst_n     = 1'b0;
    i_imem_resp = 1'b0;
    i_imem_data = '0;
    repeat (reset_cycles) @(negedge clk);
    i_rst_n = 1'b1;
  endtask

  task automatic check_retire();
    logic [36:0] want_wb;
    assert (expected.size() > 0) else begin
      abort_run($sformatf("Unexpected write to x%0d at %0t", o_wb_rd, $time));
    end
    want_wb = expected.pop_front();
    assert (o_wb_rd == want_wb[36:32] && o_wb_data == want_wb[31:0]) else begin
      report_mismatch($sformatf("write x%0d=%h, expected x%0d=%h",
                                o_wb_rd, o_wb_data, want_wb[36:32], want_wb[31:0]));
    end
  endtask

  // Runs prog until every word plus three bubbles has been fetched
  task automatic run_program(input logic random_resp, input logic check_latency);
    int          want;
    int          seen;
    int          accepted;
    int          cyc;
    int          first_accept;
    int          first_strobe;
    logic [31:0] prev_addr;
    logic        resp;
    load_program();
    want         = expected.size();
    seen         = 0;
    accepted     = 0;
    cyc          = 0;
    first_accept = -1;
    first_strobe = -1;
    cycle_limit += 4 * (prog.size() + 3) + reset_cycles + 2;
    apply_reset();
    assert (o_imem_addr == 32'h0) else begin
      report_mismatch($sformatf("fetch address %h after reset", o_imem_addr));
    end
    while (accepted < prog.size() + 3) begin
      resp        = random_resp ? 1'b0 : 1'b1;
      if (random_resp) begin
        lfsr = lfsr_next(lfsr);
        resp = lfsr[0];
      end
      i_imem_resp = resp;
      i_imem_data = mem[o_imem_addr[9:2]];
      if (resp && first_accept < 0) first_accept = cyc;
      #5;  // Mid low phase, strobe depends on resp
      if (o_wb_valid) begin
        check_retire();
        seen++;
        if (first_strobe < 0) first_strobe = cyc;
      end
      if (resp) accepted++;
      prev_addr = o_imem_addr;
      @(negedge clk);
      cyc++;
      assert (o_imem_addr == prev_addr + (resp ? 32'd4 : 32'd0)) else begin
        report_mismatch($sformatf("fetch address %h after %h, resp %b",
                                  o_imem_addr, prev_addr, resp));
      end
    end
    assert (seen == want && expected.size() == 0) else begin
      report_mismatch($sformatf("%0d writes retired, %0d expected", seen, want));
    end
    if (check_latency) begin
      assert (first_strobe - first_accept == 3) else begin
        report_mismatch($sformatf("first write %0d cycles after first fetch",
                                  first_strobe - first_accept));
      end
    end
  endtask

  task automatic alu_operations(input logic random_resp);
    prog.delete();
    prog.push_back(i_op(3'd0, 1, 0, -20));
    prog.push_back(i_op(3'd0, 2, 0, 7));
    prog.push_back(u_op(7'h37, 3, 20'h80000));
    prog.push_back(i_op(3'd0, 4, 0, 'h0f0));
    prog.push_back(r_op(7'h00, 3'd0, 5, 1, 2));   // add
    prog.push_back(r_op(7'h20, 3'd0, 6, 1, 2));   // sub
    prog.push_back(r_op(7'h00, 3'd1, 7, 2, 2));
    prog.push_back(r_op(7'h00, 3'd2, 8, 1, 2));   // -20 < 7 signed
    prog.push_back(r_op(7'h00, 3'd3, 9, 1, 2));   // But not unsigned
    prog.push_back(r_op(7'h00, 3'd4, 10, 1, 4));
    prog.push_back(r_op(7'h00, 3'd5, 11, 3, 2));  // srl
    prog.push_back(r_op(7'h20, 3'd5, 12, 3, 2));  // sra
    prog.push_back(r_op(7'h00, 3'd6, 13, 1, 4));
    prog.push_back(r_op(7'h00, 3'd7, 14, 1, 4));
    prog.push_back(i_op(3'd0, 15, 1, 100));
    prog.push_back(i_op(3'd2, 16, 1, -1));
    prog.push_back(i_op(3'd3, 17, 2, -1));
    prog.push_back(i_op(3'd4, 18, 4, -1));
    prog.push_back(i_op(3'd6, 19, 2, 'h700));
    prog.push_back(i_op(3'd7, 20, 1, 'h0ff));
    prog.push_back(i_op(3'd1, 21, 2, 31));
    prog.push_back(i_op(3'd5, 22, 3, 4));         // srli
    prog.push_back(i_op(3'd5, 23, 3, 'h404));     // srai
    run_program(random_resp, !random_resp);
  endtask

  // Consumers one and two slots behind their producers
  task automatic dependent_chains(input logic random_resp);
    prog.delete();
    prog.push_back(i_op(3'd0, 1, 0, 3));
    prog.push_back(i_op(3'd0, 1, 1, 1));
    prog.push_back(r_op(7'h00, 3'd0, 2, 1, 1));
    prog.push_back(r_op(7'h20, 3'd0, 3, 2, 1));
    prog.push_back(i_op(3'd1, 4, 3, 3));
    prog.push_back(r_op(7'h00, 3'd4, 5, 4, 3));
    prog.push_back(r_op(7'h00, 3'd6, 5, 5, 4));
    prog.push_back(i_op(3'd0, 6, 0, -1));
    prog.push_back(i_op(3'd0, 7, 0, 9));
    prog.push_back(r_op(7'h20, 3'd5, 8, 6, 7));
    prog.push_back(r_op(7'h00, 3'd3, 9, 8, 7));
    prog.push_back(r_op(7'h00, 3'd0, 10, 9, 5));
    prog.push_back(r_op(7'h20, 3'd0, 11, 0, 10));
    prog.push_back(i_op(3'd5, 12, 11, 'h402));
    run_program(random_resp, 1'b0);
  endtask

  task automatic upper_immediates();
    prog.delete();
    prog.push_back(u_op(7'h37, 1, 20'h12345));
    prog.push_back(u_op(7'h17, 2, 20'h00001));
    prog.push_back(u_op(7'h17, 3, 20'hfffff));
    prog.push_back(i_op(3'd0, 4, 1, 'h678));
    prog.push_back(u_op(7'h37, 5, 20'h80000));
    prog.push_back(r_op(7'h00, 3'd0, 6, 2, 3));
    run_program(1'b0, 1'b0);
  endtask

  task automatic x0_and_illegal_words();
    prog.delete();
    prog.push_back(i_op(3'd0, 0, 0, 55));
    prog.push_back(r_op(7'h00, 3'd0, 1, 0, 0));
    prog.push_back(32'h0000_0000);
    prog.push_back(i_op(3'd0, 2, 0, 77));
    prog.push_back(32'hffff_ffff);
    prog.push_back(r_op(7'h01, 3'd0, 3, 2, 2));   // MUL
    prog.push_back(i_op(3'd1, 4, 2, 'h402));      // slli with funct7 set
    prog.push_back(32'h0000_0063);                // Branch
    prog.push_back(u_op(7'h37, 0, 20'habcde));
    prog.push_back(r_op(7'h00, 3'd3, 5, 0, 2));
    prog.push_back(r_op(7'h00, 3'd6, 6, 0, 0));
    run_program(1'b0, 1'b0);
  endtask

  initial begin
    alu_operations(1'b0);
    dependent_chains(1'b0);
    upper_immediates();
    x0_and_illegal_words();
    alu_operations(1'b1);    // Same programs under random freezes
    dependent_chains(1'b1);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/rv32i_pkg.sv
hdl/alu.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/int_pipeline.sv
bench/tb_int_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_int_pipeline
RTL_TOP   ?= int_pipeline
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard hdl/*.sv bench/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
